// ==== rv_mdu_pkg.sv ====
/* Shared types and constants of the RV32M multiply/divide unit:
   data word, operation code, APB register offset, accumulator width,
   RV32M funct3 codes and the APB register map */
`default_nettype none

package rv_mdu_pkg;

    typedef logic [31:0] word_t;      // Operands, results and APB data
    typedef logic [2:0]  mdu_op_t;    // RV32M funct3
    typedef logic [4:0]  reg_addr_t;  // APB byte offset
    typedef logic [34:0] mac_t;       // 17x17 signed product plus carry room

    localparam mdu_op_t OP_MUL    = 3'd0;
    localparam mdu_op_t OP_MULH   = 3'd1;
    localparam mdu_op_t OP_MULHSU = 3'd2;
    localparam mdu_op_t OP_MULHU  = 3'd3;
    localparam mdu_op_t OP_DIV    = 3'd4;
    localparam mdu_op_t OP_DIVU   = 3'd5;
    localparam mdu_op_t OP_REM    = 3'd6;
    localparam mdu_op_t OP_REMU   = 3'd7;

    localparam reg_addr_t ADDR_OPA    = 5'h00;
    localparam reg_addr_t ADDR_OPB    = 5'h04;
    localparam reg_addr_t ADDR_CTRL   = 5'h08;  // Op in 2:0, start in bit 8
    localparam reg_addr_t ADDR_STATUS = 5'h0C;  // Busy in bit 0, done in bit 1
    localparam reg_addr_t ADDR_RESULT = 5'h10;

    localparam int CTRL_START_BIT = 8;

endpackage

`default_nettype wire

// ==== mul_if.sv ====
/* Link between the MDU controller and the 16x16 MAC multiplier */
`timescale 1ns/1ns
`default_nettype none

interface mul_if;

    rv_mdu_pkg::word_t first_operand;
    rv_mdu_pkg::word_t second_operand;
    logic [1:0]        signed_mode;     // Bit 0 is A signed, bit 1 is B signed
    logic              enable;
    logic              mul_low;
    logic              single_cycle;
    logic              hold;
    rv_mdu_pkg::word_t result;

    modport ctrl (
        output first_operand, second_operand, signed_mode, enable, mul_low, single_cycle,
        input  hold, result
    );

    modport unit (
        input  first_operand, second_operand, signed_mode, enable, mul_low, single_cycle,
        output hold, result
    );

endinterface

`default_nettype wire

// ==== div_if.sv ====
/* Link between the MDU controller and the radix-2 divider */
`timescale 1ns/1ns
`default_nettype none

interface div_if;

    rv_mdu_pkg::word_t dividend;
    rv_mdu_pkg::word_t divisor;
    logic              is_signed;
    logic              want_rem;
    logic              start;       // Operands are sampled with this pulse
    logic              busy;
    rv_mdu_pkg::word_t result;

    modport ctrl (
        output dividend, divisor, is_signed, want_rem, start,
        input  busy, result
    );

    modport unit (
        input  dividend, divisor, is_signed, want_rem, start,
        output busy, result
    );

endinterface

`default_nettype wire

// ==== mul.sv ====
/* Multi-cycle 16x16 multiply-accumulate multiplier
   Low words take three partial products, high words four, and small MUL
   operands use a single-cycle path */
`timescale 1ns/1ns
`default_nettype none

module mul (
    input wire  clk,
    input wire  reset_n,
    mul_if.unit m
);

    typedef enum logic [1:0] {
        ALBL,
        ALBH,
        AHBL,
        AHBH
    } mul_state_e;

    mul_state_e        state;
    mul_state_e        state_nx;
    rv_mdu_pkg::mac_t  acc_q;     // Running sum between partial products
    rv_mdu_pkg::mac_t  acc_in;
    rv_mdu_pkg::mac_t  mac;
    rv_mdu_pkg::mac_t  mac_keep;  // Value stored for the next step
    logic [15:0]       op_a;
    logic [15:0]       op_b;
    logic              sign_a;
    logic              sign_b;
    logic              signed_mult;

    assign signed_mult = |m.signed_mode;
    assign mac         = $signed({sign_a, op_a}) * $signed({sign_b, op_b}) + $signed(acc_in);
    assign m.result    = mac_keep[31:0];

    always_comb begin
        op_a     = m.first_operand[15:0];
        op_b     = m.second_operand[15:0];
        sign_a   = 1'b0;
        sign_b   = 1'b0;
        acc_in   = '0;
        mac_keep = mac;
        m.hold   = 1'b0;
        state_nx = ALBL;

        case (state)
            ALBL: begin
                // The fast path treats both operands as 16-bit values
                if (m.single_cycle && !m.enable) begin
                    sign_a = m.first_operand[15] & m.signed_mode[0];
                    sign_b = m.second_operand[15] & m.signed_mode[1];
                end
                m.hold   = m.enable;
                state_nx = m.enable ? ALBH : ALBL;
            end
            ALBH: begin
                op_b   = m.second_operand[31:16];
                sign_b = m.second_operand[31] & m.signed_mode[1];
                acc_in = {19'b0, acc_q[31:16]};
                if (m.mul_low)
                    mac_keep = {3'b0, mac[15:0], acc_q[15:0]};  // Keep AL*BL low half
                m.hold   = 1'b1;
                state_nx = AHBL;
            end
            AHBL: begin
                op_a   = m.first_operand[31:16];
                sign_a = m.first_operand[31] & m.signed_mode[0];
                if (m.mul_low) begin
                    acc_in   = {19'b0, acc_q[31:16]};
                    mac_keep = {3'b0, mac[15:0], acc_q[15:0]};
                end else begin
                    acc_in   = acc_q;
                    m.hold   = 1'b1;
                    state_nx = AHBH;
                end
            end
            default: begin
                op_a   = m.first_operand[31:16];
                op_b   = m.second_operand[31:16];
                sign_a = m.first_operand[31] & m.signed_mode[0];
                sign_b = m.second_operand[31] & m.signed_mode[1];
                // Upper half of the middle sum, extended with its own sign
                acc_in = {{17{signed_mult & acc_q[33]}}, acc_q[33:16]};
            end
        endcase
    end

    always_ff @(posedge clk) begin
        acc_q <= mac_keep;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= ALBL;
        end else begin
            state <= state_nx;
        end
    end

endmodule

`default_nettype wire

// ==== div.sv ====
/* Iterative radix-2 restoring divider for DIV, DIVU, REM and REMU
   Works on magnitudes, retires DIV_UNROLL quotient bits per cycle and
   restores the signs, with the RISC-V divide-by-zero result */
`timescale 1ns/1ns
`default_nettype none

module div #(
    parameter int DIV_UNROLL = 1
) (
    input wire  clk,
    input wire  reset_n,
    div_if.unit d
);

    localparam int STEPS = 32 / DIV_UNROLL;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FIX
    } div_state_e;

    div_state_e        state;
    logic [5:0]        cnt;
    rv_mdu_pkg::word_t quot;       // Shifts out dividend bits, shifts in quotient bits
    rv_mdu_pkg::word_t rem;
    rv_mdu_pkg::word_t dsor;
    rv_mdu_pkg::word_t q_nx;
    rv_mdu_pkg::word_t r_nx;
    rv_mdu_pkg::word_t abs_a;
    rv_mdu_pkg::word_t abs_b;
    logic [32:0]       trial;
    logic              div_zero;
    logic              q_neg;
    logic              r_neg;
    logic              want_rem;

    assign abs_a    = (d.is_signed && d.dividend[31]) ? -d.dividend : d.dividend;
    assign abs_b    = (d.is_signed && d.divisor[31]) ? -d.divisor : d.divisor;
    assign div_zero = (d.divisor == '0);
    assign d.busy   = (state == RUN);

    // Sign restore is combinational and is read while in FIX
    assign d.result = want_rem ? (r_neg ? -rem : rem) : (q_neg ? -quot : quot);

    always_comb begin
        q_nx  = quot;
        r_nx  = rem;
        trial = '0;
        for (int i = 0; i < DIV_UNROLL; i++) begin
            trial = {r_nx, q_nx[31]} - {1'b0, dsor};
            if (!trial[32])
                r_nx = trial[31:0];
            else
                r_nx = {r_nx[30:0], q_nx[31]};
            q_nx = {q_nx[30:0], !trial[32]};
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (d.start) begin
                        state <= div_zero ? FIX : RUN;
                        cnt   <= 6'(STEPS - 1);
                    end
                end
                RUN: begin
                    if (cnt == '0)
                        state <= FIX;
                    cnt <= cnt - 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && d.start) begin
            dsor     <= abs_b;
            quot     <= div_zero ? '1 : abs_a;
            rem      <= div_zero ? abs_a : '0;
            q_neg    <= d.is_signed & (d.dividend[31] ^ d.divisor[31]) & !div_zero;
            r_neg    <= d.is_signed & d.dividend[31];
            want_rem <= d.want_rem;
        end else if (state == RUN) begin
            quot <= q_nx;
            rem  <= r_nx;
        end
    end

endmodule

`default_nettype wire

// ==== mdu_ctrl.sv ====
/* MDU controller: latches the request, decodes the operation, picks the
   fast or multi-cycle multiply or the divider and returns result and done */
`timescale 1ns/1ns
`default_nettype none

module mdu_ctrl (
    input wire                  clk,
    input wire                  reset_n,
    input wire                  start_i,
    input wire rv_mdu_pkg::mdu_op_t op_i,
    input wire rv_mdu_pkg::word_t   opa_i,
    input wire rv_mdu_pkg::word_t   opb_i,
    output logic                busy_o,
    output logic                done_o,
    output rv_mdu_pkg::word_t   result_o,
    mul_if.ctrl                 m,
    div_if.ctrl                 d
);

    typedef enum logic [1:0] {
        IDLE,
        MUL,
        DIV,
        FAST
    } ctrl_state_e;

    ctrl_state_e         state;
    rv_mdu_pkg::mdu_op_t op_q;
    rv_mdu_pkg::word_t   opa_q;
    rv_mdu_pkg::word_t   opb_q;
    logic [1:0]          sm_q;
    logic [1:0]          sm_d;
    logic                is_div;
    logic                fits_s;
    logic                fits_u;
    logic                fast;

    assign is_div = op_i inside {rv_mdu_pkg::OP_DIV, rv_mdu_pkg::OP_DIVU,
                                 rv_mdu_pkg::OP_REM, rv_mdu_pkg::OP_REMU};
    assign fits_s = (opa_i[31:15] == '0 || opa_i[31:15] == '1) &&
                    (opb_i[31:15] == '0 || opb_i[31:15] == '1);
    assign fits_u = (opa_i[31:16] == '0) && (opb_i[31:16] == '0);
    assign fast   = (op_i == rv_mdu_pkg::OP_MUL) && (fits_s || fits_u);

    always_comb begin
        case (op_i)
            rv_mdu_pkg::OP_MULH:   sm_d = 2'b11;
            rv_mdu_pkg::OP_MULHSU: sm_d = 2'b01;
            rv_mdu_pkg::OP_MULHU:  sm_d = 2'b00;
            default:               sm_d = fits_u ? 2'b00 : 2'b11;  // MUL low word
        endcase
    end

    assign busy_o = (state != IDLE);

    assign m.first_operand  = opa_q;
    assign m.second_operand = opb_q;
    assign m.signed_mode    = sm_q;
    assign m.enable         = (state == MUL);
    assign m.single_cycle   = (state == FAST);
    assign m.mul_low        = (op_q == rv_mdu_pkg::OP_MUL);

    // The divider samples its operands straight from the request cycle
    assign d.dividend  = opa_i;
    assign d.divisor   = opb_i;
    assign d.is_signed = (op_i == rv_mdu_pkg::OP_DIV) || (op_i == rv_mdu_pkg::OP_REM);
    assign d.want_rem  = (op_i == rv_mdu_pkg::OP_REM) || (op_i == rv_mdu_pkg::OP_REMU);
    assign d.start     = start_i && (state == IDLE) && is_div;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state  <= IDLE;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                IDLE: begin
                    if (start_i && is_div)
                        state <= DIV;
                    else if (start_i)
                        state <= fast ? FAST : MUL;
                end
                MUL: begin
                    if (!m.hold) begin
                        state  <= IDLE;
                        done_o <= 1'b1;
                    end
                end
                DIV: begin
                    if (!d.busy) begin
                        state  <= IDLE;
                        done_o <= 1'b1;
                    end
                end
                default: begin
                    state  <= IDLE;
                    done_o <= 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_i && state == IDLE) begin
            op_q  <= op_i;
            opa_q <= opa_i;
            opb_q <= opb_i;
            sm_q  <= sm_d;
        end
        if (state == FAST || (state == MUL && !m.hold))
            result_o <= m.result;
        else if (state == DIV && !d.busy)
            result_o <= d.result;
    end

endmodule

`default_nettype wire

// ==== apb_mdu_regs.sv ====
/* APB slave of the MDU: operand, control, status and result registers,
   start pulse generation and PSLVERR for unmapped or misaligned offsets */
`timescale 1ns/1ns
`default_nettype none

module apb_mdu_regs (
    input wire                        clk,
    input wire                        reset_n,
    input wire                        psel_i,
    input wire                        penable_i,
    input wire                        pwrite_i,
    input wire rv_mdu_pkg::reg_addr_t paddr_i,
    input wire rv_mdu_pkg::word_t     pwdata_i,
    output rv_mdu_pkg::word_t         prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,
    output logic                      start_o,
    output rv_mdu_pkg::mdu_op_t       op_o,
    output rv_mdu_pkg::word_t         opa_o,
    output rv_mdu_pkg::word_t         opb_o,
    input wire                        busy_i,
    input wire                        done_i,
    input wire rv_mdu_pkg::word_t     result_i
);

    rv_mdu_pkg::word_t result_q;
    logic              done_q;
    logic              access;
    logic              wr;
    logic              addr_ok;
    logic              busy_all;
    logic              go;

    assign access   = psel_i & penable_i;
    assign wr       = access & pwrite_i;
    assign addr_ok  = paddr_i inside {rv_mdu_pkg::ADDR_OPA, rv_mdu_pkg::ADDR_OPB,
                                      rv_mdu_pkg::ADDR_CTRL, rv_mdu_pkg::ADDR_STATUS,
                                      rv_mdu_pkg::ADDR_RESULT};
    assign busy_all = busy_i | start_o;  // Busy shows from the start edge on
    assign go       = wr && (paddr_i == rv_mdu_pkg::ADDR_CTRL) &&
                      pwdata_i[rv_mdu_pkg::CTRL_START_BIT] && !busy_all;

    assign pready_o  = 1'b1;
    assign pslverr_o = access & !addr_ok;

    always_comb begin
        prdata_o = '0;
        if (psel_i && !pwrite_i) begin
            case (paddr_i)
                rv_mdu_pkg::ADDR_OPA:    prdata_o = opa_o;
                rv_mdu_pkg::ADDR_OPB:    prdata_o = opb_o;
                rv_mdu_pkg::ADDR_CTRL:   prdata_o = {29'b0, op_o};
                rv_mdu_pkg::ADDR_STATUS: prdata_o = {30'b0, done_q, busy_all};
                rv_mdu_pkg::ADDR_RESULT: prdata_o = result_q;
                default:                 prdata_o = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            start_o  <= 1'b0;
            op_o     <= '0;
            opa_o    <= '0;
            opb_o    <= '0;
            done_q   <= 1'b0;
            result_q <= '0;
        end else begin
            start_o <= go;
            if (wr && paddr_i == rv_mdu_pkg::ADDR_OPA)
                opa_o <= pwdata_i;
            if (wr && paddr_i == rv_mdu_pkg::ADDR_OPB)
                opb_o <= pwdata_i;
            if (wr && paddr_i == rv_mdu_pkg::ADDR_CTRL)
                op_o <= pwdata_i[2:0];
            if (done_i) begin
                done_q   <= 1'b1;
                result_q <= result_i;
            end
            if (go)
                done_q <= 1'b0;  // A new start clears the sticky flag
        end
    end

endmodule

`default_nettype wire

// ==== mdu_top.sv ====
/* Top level of the APB multiply/divide unit: register block, controller,
   multiplier and divider */
`timescale 1ns/1ns
`default_nettype none

module mdu_top #(
    parameter int DIV_UNROLL = 1
) (
    input wire                        clk,
    input wire                        reset_n,
    input wire                        psel_i,
    input wire                        penable_i,
    input wire                        pwrite_i,
    input wire rv_mdu_pkg::reg_addr_t paddr_i,
    input wire rv_mdu_pkg::word_t     pwdata_i,
    output rv_mdu_pkg::word_t         prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o
);

    logic                start;
    logic                busy;
    logic                done;
    rv_mdu_pkg::mdu_op_t op;
    rv_mdu_pkg::word_t   opa;
    rv_mdu_pkg::word_t   opb;
    rv_mdu_pkg::word_t   result;

    mul_if mul_bus ();
    div_if div_bus ();

    apb_mdu_regs u_regs (
        .clk       (clk),
        .reset_n   (reset_n),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .start_o   (start),
        .op_o      (op),
        .opa_o     (opa),
        .opb_o     (opb),
        .busy_i    (busy),
        .done_i    (done),
        .result_i  (result)
    );

    mdu_ctrl u_ctrl (
        .clk      (clk),
        .reset_n  (reset_n),
        .start_i  (start),
        .op_i     (op),
        .opa_i    (opa),
        .opb_i    (opb),
        .busy_o   (busy),
        .done_o   (done),
        .result_o (result),
        .m        (mul_bus.ctrl),
        .d        (div_bus.ctrl)
    );

    mul u_mul (
        .clk     (clk),
        .reset_n (reset_n),
        .m       (mul_bus.unit)
    );

    div #(
        .DIV_UNROLL (DIV_UNROLL)
    ) u_div (
        .clk     (clk),
        .reset_n (reset_n),
        .d       (div_bus.unit)
    );

endmodule

`default_nettype wire

// ==== mdu_assert.sv ====
/* Concurrent checks bound into the MDU top level: PSLVERR timing,
   multiplier hold length, done pulse shape and start acceptance */
`timescale 1ns/1ns
`default_nettype none

module mdu_assert (
    input wire clk,
    input wire reset_n,
    input wire psel_i,
    input wire penable_i,
    input wire pslverr_i,
    input wire start_i,
    input wire busy_i,
    input wire done_i,
    input wire hold_i
);

    int assert_fails = 0;

    slverr_in_access: assert property (@(posedge clk) disable iff (!reset_n)
        pslverr_i |-> (psel_i && penable_i))
        else begin
            $error("PSLVERR high outside an APB access phase");
            assert_fails++;
        end

    hold_max_three: assert property (@(posedge clk) disable iff (!reset_n)
        hold_i [*3] |=> !hold_i)
        else begin
            $error("Multiplier hold stayed high for more than 3 cycles");
            assert_fails++;
        end

    done_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        done_i |=> !done_i)
        else begin
            $error("Done pulse longer than one cycle");
            assert_fails++;
        end

    done_after_busy: assert property (@(posedge clk) disable iff (!reset_n)
        done_i |-> $past(busy_i))
        else begin
            $error("Done pulse without a preceding busy cycle");
            assert_fails++;
        end

    start_when_idle: assert property (@(posedge clk) disable iff (!reset_n)
        start_i |-> !busy_i)
        else begin
            $error("Start accepted while the controller was busy");
            assert_fails++;
        end

endmodule

bind mdu_top mdu_assert u_assert (
    .clk       (clk),
    .reset_n   (reset_n),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pslverr_i (pslverr_o),
    .start_i   (start),
    .busy_i    (busy),
    .done_i    (done),
    .hold_i    (mul_bus.hold)
);

`default_nettype wire

// ==== tb_mdu.sv ====
/* Directed testbench of the APB multiply/divide unit with clock, reset,
   APB tasks, RV32M reference model, compare tasks and cycle timeout */
`timescale 1ns/1ns
`default_nettype none

module tb_mdu;

    localparam int N_OPS         = 200;  // Upper bound on operations run by all tests
    localparam int CYCLES_PER_OP = 50;
    localparam int MAX_CYCLES    = N_OPS * CYCLES_PER_OP + 500;

    logic                  clk;
    logic                  reset_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    rv_mdu_pkg::reg_addr_t paddr;
    rv_mdu_pkg::word_t     pwdata;
    rv_mdu_pkg::word_t     prdata;
    logic                  pready;
    logic                  pslverr;
    int                    errors = 0;
    int                    checks = 0;
    int                    cycles = 0;

    mdu_top #(
        .DIV_UNROLL (1)
    ) UUT (
        .clk       (clk),
        .reset_n   (reset_n),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: run exceeded %0d clock cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_word(input string what, input rv_mdu_pkg::word_t got,
                              input rv_mdu_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error @ %0t ns: %s: got 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error @ %0t ns: %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Setup phase, access phase, then back to idle
    task automatic apb_write(input rv_mdu_pkg::reg_addr_t addr, input rv_mdu_pkg::word_t data);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        pwrite  = 1'b1;
        penable = 1'b0;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input rv_mdu_pkg::reg_addr_t addr, output rv_mdu_pkg::word_t data,
                            output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        pwrite  = 1'b0;
        penable = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);  // Mid access phase
        data = prdata;
        err  = pslverr;
        check_flag("PREADY in access phase", pready, 1'b1);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    function automatic rv_mdu_pkg::word_t ctrl_start_word(input rv_mdu_pkg::mdu_op_t op);
        return rv_mdu_pkg::word_t'(op) | (32'd1 << rv_mdu_pkg::CTRL_START_BIT);
    endfunction

    // RV32M results straight from the ISA rules
    function automatic rv_mdu_pkg::word_t ref_result(input rv_mdu_pkg::mdu_op_t op,
                                                     input rv_mdu_pkg::word_t a,
                                                     input rv_mdu_pkg::word_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] za;
        logic signed [63:0] zb;
        logic [63:0]        prod;
        logic               ovf;
        sa   = {{32{a[31]}}, a};
        sb   = {{32{b[31]}}, b};
        za   = {32'b0, a};
        zb   = {32'b0, b};
        ovf  = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
        prod = '0;
        case (op)
            rv_mdu_pkg::OP_MUL: begin
                prod = sa * sb;
                return prod[31:0];
            end
            rv_mdu_pkg::OP_MULH: begin
                prod = sa * sb;
                return prod[63:32];
            end
            rv_mdu_pkg::OP_MULHSU: begin
                prod = sa * zb;
                return prod[63:32];
            end
            rv_mdu_pkg::OP_MULHU: begin
                prod = za * zb;
                return prod[63:32];
            end
            rv_mdu_pkg::OP_DIV: begin
                if (b == '0)
                    return '1;
                if (ovf)
                    return a;
                return $signed(a) / $signed(b);
            end
            rv_mdu_pkg::OP_DIVU: return (b == '0) ? '1 : a / b;
            rv_mdu_pkg::OP_REM: begin
                if (b == '0)
                    return a;
                if (ovf)
                    return '0;
                return $signed(a) % $signed(b);
            end
            default: return (b == '0) ? a : a % b;
        endcase
    endfunction

    task automatic wait_done;
        rv_mdu_pkg::word_t st;
        logic              err;
        st = '0;
        while (!st[1])
            apb_read(rv_mdu_pkg::ADDR_STATUS, st, err);
    endtask

    task automatic run_op(input rv_mdu_pkg::mdu_op_t op, input rv_mdu_pkg::word_t a,
                          input rv_mdu_pkg::word_t b, output rv_mdu_pkg::word_t res);
        logic err;
        apb_write(rv_mdu_pkg::ADDR_OPA, a);
        apb_write(rv_mdu_pkg::ADDR_OPB, b);
        apb_write(rv_mdu_pkg::ADDR_CTRL, ctrl_start_word(op));
        wait_done();
        apb_read(rv_mdu_pkg::ADDR_RESULT, res, err);
    endtask

    task automatic verify_op(input rv_mdu_pkg::mdu_op_t op, input rv_mdu_pkg::word_t a,
                             input rv_mdu_pkg::word_t b);
        rv_mdu_pkg::word_t res;
        run_op(op, a, b, res);
        check_word($sformatf("op %0d a=%08h b=%08h", op, a, b), res, ref_result(op, a, b));
    endtask

    task automatic test_registers;
        rv_mdu_pkg::word_t data;
        rv_mdu_pkg::word_t pat;
        logic              err;
        apb_read(rv_mdu_pkg::ADDR_STATUS, data, err);
        check_word("STATUS after reset", data, '0);
        check_flag("PSLVERR on STATUS read", err, 1'b0);
        pat = $urandom;
        apb_write(rv_mdu_pkg::ADDR_OPA, pat);
        apb_read(rv_mdu_pkg::ADDR_OPA, data, err);
        check_word("OPA read back", data, pat);
        pat = $urandom;
        apb_write(rv_mdu_pkg::ADDR_OPB, pat);
        apb_read(rv_mdu_pkg::ADDR_OPB, data, err);
        check_word("OPB read back", data, pat);
        apb_read(5'h14, data, err);
        check_flag("PSLVERR on unmapped offset", err, 1'b1);
        check_word("Data on unmapped offset", data, '0);
        apb_read(5'h06, data, err);
        check_flag("PSLVERR on misaligned offset", err, 1'b1);
        check_word("Data on misaligned offset", data, '0);
    endtask

    task automatic test_multiplies;
        rv_mdu_pkg::word_t corners [5];
        corners = '{32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF};
        for (int op = 0; op < 4; op++)
            for (int i = 0; i < 5; i++)
                for (int j = 0; j < 5; j++)
                    verify_op(rv_mdu_pkg::mdu_op_t'(op), corners[i], corners[j]);
        for (int n = 0; n < 40; n++)
            verify_op(rv_mdu_pkg::mdu_op_t'(n % 4), $urandom, $urandom);
    endtask

    task automatic test_fast_path;
        verify_op(rv_mdu_pkg::OP_MUL, 32'd3, 32'd5);
        verify_op(rv_mdu_pkg::OP_MUL, 32'hFFFF_FFF9, 32'd100);       // -7 * 100
        verify_op(rv_mdu_pkg::OP_MUL, 32'hFFFF_8000, 32'hFFFF_8000);
        verify_op(rv_mdu_pkg::OP_MUL, 32'h0000_FFFF, 32'h0000_FFFF);
        verify_op(rv_mdu_pkg::OP_MUL, 32'hFFFF_FFFF, 32'h0000_7FFF);
        verify_op(rv_mdu_pkg::OP_MUL, 32'h0001_0000, 32'd3);         // Just past 16 bits
        verify_op(rv_mdu_pkg::OP_MUL, 32'hFFFF_7FFF, 32'd2);
        verify_op(rv_mdu_pkg::OP_MUL, 32'h0000_FFFF, 32'hFFFF_FFFF);
    endtask

    task automatic test_divides;
        rv_mdu_pkg::word_t a;
        rv_mdu_pkg::word_t b;
        for (int n = 0; n < 20; n++) begin
            a = $urandom;
            b = $urandom >> ($urandom % 28);  // Spread divisor sizes
            verify_op(rv_mdu_pkg::mdu_op_t'(4 + n % 4), a, b);
        end
        for (int op = 4; op < 8; op++) begin
            verify_op(rv_mdu_pkg::mdu_op_t'(op), $urandom, 32'd0);
            verify_op(rv_mdu_pkg::mdu_op_t'(op), 32'h8000_0000, 32'hFFFF_FFFF);
        end
    endtask

    task automatic test_busy;
        rv_mdu_pkg::word_t st;
        rv_mdu_pkg::word_t res;
        logic              err;
        apb_write(rv_mdu_pkg::ADDR_OPA, 32'd1_000_000);
        apb_write(rv_mdu_pkg::ADDR_OPB, 32'd7);
        apb_write(rv_mdu_pkg::ADDR_CTRL, ctrl_start_word(rv_mdu_pkg::OP_DIVU));
        apb_read(rv_mdu_pkg::ADDR_STATUS, st, err);
        check_flag("Busy during divide", st[0], 1'b1);
        check_flag("Done during divide", st[1], 1'b0);
        // Second request lands while the divide is still running
        apb_write(rv_mdu_pkg::ADDR_OPA, 32'd5);
        apb_write(rv_mdu_pkg::ADDR_OPB, 32'd1);
        apb_write(rv_mdu_pkg::ADDR_CTRL, ctrl_start_word(rv_mdu_pkg::OP_REM));
        wait_done();
        apb_read(rv_mdu_pkg::ADDR_RESULT, res, err);
        check_word("Result after ignored start", res,
                   ref_result(rv_mdu_pkg::OP_DIVU, 32'd1_000_000, 32'd7));
        apb_write(rv_mdu_pkg::ADDR_CTRL, ctrl_start_word(rv_mdu_pkg::OP_DIV));
        apb_read(rv_mdu_pkg::ADDR_STATUS, st, err);
        check_flag("Done cleared by new start", st[1], 1'b0);
        check_flag("Busy after new start", st[0], 1'b1);
        wait_done();
        apb_read(rv_mdu_pkg::ADDR_RESULT, res, err);
        check_word("Result of new divide", res, ref_result(rv_mdu_pkg::OP_DIV, 32'd5, 32'd1));
    endtask

    initial begin
        void'($urandom(89));
        reset_n = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (16) @(posedge clk);
        #1;
        reset_n = 1'b1;

        test_registers();
        test_multiplies();
        test_fast_path();
        test_divides();
        test_busy();

        errors += UUT.u_assert.assert_fails;
        $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, UUT.u_assert.assert_fails);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv_mdu.f ====
rv_mdu_pkg.sv
mul_if.sv
div_if.sv
mul.sv
div.sv
mdu_ctrl.sv
apb_mdu_regs.sv
mdu_top.sv
mdu_assert.sv
tb_mdu.sv
